// File: cache_bus_adapter.f
logic/cache_bus_pkg.sv
logic/id_fifo.sv
logic/req_arbiter.sv
logic/wr_resp_counter.sv
logic/line_assembler.sv
logic/rtrn_router.sv
logic/cache_bus_adapter.sv
testbench/tb_cache_bus_adapter_assert.sv
testbench/tb_cache_bus_adapter.sv

// File: Makefile
TOP = tb_cache_bus_adapter

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f cache_bus_adapter.f --top-module $(TOP)

obj_dir/V$(TOP): cache_bus_adapter.f logic/*.sv testbench/*.sv
	verilator --binary --timing --assert -f cache_bus_adapter.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_cache_bus_adapter.sv
/* Testbench of the cache bus adapter: random requests from both caches,
   a memory model on the bus side and an in-order return checker */
`timescale 1ns/100ps
module tb_cache_bus_adapter import cache_bus_pkg::*; ();

  localparam int REQS_PER_CACHE = 100;
  localparam int CYCLE_LIMIT    = 2 * REQS_PER_CACHE * 40;

  typedef struct packed {
    logic       store;
    logic       nc;
    logic       line;
    logic [1:0] size;
    tid_t       tid;
    paddr_t     addr;
    word_t      wdata;
  } req_rec_t;

  typedef struct packed {
    paddr_t base;
    blen_t  blen;
    logic   id;
  } burst_t;

  logic clk_i;
  logic arst_n_i;
  logic icache_data_req_i, icache_data_ack_o, icache_nc_i;
  paddr_t icache_paddr_i;
  tid_t icache_tid_i, icache_rtrn_tid_o;
  logic icache_rtrn_vld_o;
  word_t [ICACHE_LINE_WORDS-1:0] icache_rtrn_data_o;
  logic dcache_data_req_i, dcache_data_ack_o, dcache_rtrn_vld_o;
  dcache_rtype_e dcache_rtype_i;
  paddr_t dcache_paddr_i;
  dsize_t dcache_size_i;
  word_t dcache_wdata_i;
  tid_t dcache_tid_i, dcache_rtrn_tid_o;
  dcache_rtrn_e dcache_rtrn_type_o;
  word_t [DCACHE_LINE_WORDS-1:0] dcache_rtrn_data_o;
  logic rd_req_o, rd_gnt_i, rd_id_o, rd_valid_i, rd_last_i, rd_id_i;
  paddr_t rd_addr_o, wr_addr_o;
  blen_t rd_blen_o;
  logic [1:0] rd_size_o;
  word_t rd_data_i, wr_data_o;
  logic wr_req_o, wr_gnt_i, wr_resp_valid_i, wr_rdy_o;
  be_t wr_be_o;

  logic [31:0] lcg_state = 32'hcc795ef8;
  logic [31:0] ic_rand;
  logic [31:0] dc_rand;
  logic [31:0] mem_rand;
  int value_errors = 0;
  int other_errors = 0;
  int ic_issued = 0;
  int dc_issued = 0;
  int returned = 0;
  int cycles = 0;
  req_rec_t ic_bus_q[$], dc_bus_q[$], ic_rtrn_q[$], ld_rtrn_q[$], st_rtrn_q[$];
  burst_t burst_q[$];

  cache_bus_adapter cache_bus_adapter_inst (.*);

  ////////////////////
  // reference model

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // memory content seen by every read
  function automatic word_t mem_word(input paddr_t addr);
    return {2{addr ^ 32'h5a3c_96e1}};
  endfunction

  // count the bytes, align the offset down to them, set that many enables
  function automatic be_t expected_be(input paddr_t addr, input logic [1:0] size);
    int nbytes;
    int start;
    nbytes = 1 << size;
    start  = (int'(addr[2:0]) / nbytes) * nbytes;
    return be_t'(((1 << nbytes) - 1) << start);
  endfunction

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    value_errors++;
  endtask

  ////////////////////
  // clock and reset

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    arst_n_i = 1'b0;
    icache_data_req_i = 1'b0;
    icache_paddr_i = '0;
    icache_nc_i = 1'b0;
    icache_tid_i = '0;
    dcache_data_req_i = 1'b0;
    dcache_rtype_i = DCACHE_LOAD_REQ;
    dcache_paddr_i = '0;
    dcache_size_i = '0;
    dcache_wdata_i = '0;
    dcache_tid_i = '0;
    rd_gnt_i = 1'b0;
    rd_valid_i = 1'b0;
    rd_data_i = '0;
    rd_last_i = 1'b0;
    rd_id_i = 1'b0;
    wr_gnt_i = 1'b0;
    wr_resp_valid_i = 1'b0;
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
  end

  // draws for the next rising edge, in a fixed order
  always @(negedge clk_i) begin
    ic_rand  = lcg_next();
    dc_rand  = lcg_next();
    mem_rand = lcg_next();
  end

  ////////////////////
  // cache request stimulus

  always @(posedge clk_i) begin
    logic [31:0] r;
    req_rec_t rec;
    if (arst_n_i) begin
      if (icache_data_req_i && icache_data_ack_o) begin
        rec = '0;
        rec.nc = icache_nc_i;
        rec.tid = icache_tid_i;
        rec.addr = icache_paddr_i;
        ic_bus_q.push_back(rec);
        ic_rtrn_q.push_back(rec);
        ic_issued++;
        icache_data_req_i <= 1'b0;
      end else if (!icache_data_req_i && ic_issued < REQS_PER_CACHE) begin
        r = ic_rand;
        if (r[31:30] != 2'b00) begin
          // one fetch in four bypasses the cache
          icache_nc_i <= (r[1:0] == 2'b00);
          icache_paddr_i <= (r[1:0] == 2'b00) ? {16'h8000, r[17:4], 2'b00}
                                              : {16'h8000, r[17:7], 5'b0};
          icache_tid_i <= r[9:8];
          icache_data_req_i <= 1'b1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    logic [31:0] r;
    req_rec_t rec;
    if (arst_n_i) begin
      if (dcache_data_req_i && dcache_data_ack_o) begin
        rec = '0;
        rec.store = (dcache_rtype_i == DCACHE_STORE_REQ);
        rec.line = dcache_size_i[2];
        rec.size = dcache_size_i[1:0];
        rec.tid = dcache_tid_i;
        rec.addr = dcache_paddr_i;
        rec.wdata = dcache_wdata_i;
        dc_bus_q.push_back(rec);
        if (rec.store) begin
          st_rtrn_q.push_back(rec);
        end else begin
          ld_rtrn_q.push_back(rec);
        end
        dc_issued++;
        dcache_data_req_i <= 1'b0;
      end else if (!dcache_data_req_i && dc_issued < REQS_PER_CACHE) begin
        r = dc_rand;
        if (r[31:30] != 2'b00) begin
          dcache_tid_i <= r[9:8];
          dcache_wdata_i <= {r, ~r};
          dcache_data_req_i <= 1'b1;
          if (r[2:0] < 3'd3) begin
            // any byte offset, the enables align down to the size
            dcache_rtype_i <= DCACHE_STORE_REQ;
            dcache_size_i <= {1'b0, r[4:3]};
            dcache_paddr_i <= {16'h4000, r[20:5]};
          end else if (r[3]) begin
            dcache_rtype_i <= DCACHE_LOAD_REQ;
            dcache_size_i <= 3'b111;
            dcache_paddr_i <= {16'h4000, r[20:9], 4'b0};
          end else begin
            dcache_rtype_i <= DCACHE_LOAD_REQ;
            dcache_size_i <= {1'b0, r[5:4]};
            dcache_paddr_i <= {16'h4000, r[21:6]} & ~((32'd1 << r[5:4]) - 1);
          end
        end
      end
    end
  end

  ////////////////////
  // bus memory model

  int write_pending = 0;
  int resp_unacked = 0;
  logic beat_active = 1'b0;
  int beat_idx = 0;
  burst_t cur;

  always @(posedge clk_i) begin
    logic [31:0] r;
    req_rec_t exp;
    burst_t b;
    if (arst_n_i) begin
      r = mem_rand;
      if (rd_req_o && rd_gnt_i) begin
        if (rd_id_o ? dc_bus_q.size() == 0 : ic_bus_q.size() == 0) begin
          $display("bus read with no matching cache request at t=%0t", $time);
          other_errors++;
        end else begin
          exp = rd_id_o ? dc_bus_q.pop_front() : ic_bus_q.pop_front();
          if (exp.store) begin
            $display("store request issued as bus read at t=%0t", $time);
            other_errors++;
          end
          if (rd_addr_o != exp.addr) report_mismatch("rd_addr_o", rd_addr_o, exp.addr);
          if (rd_id_o && rd_blen_o != blen_t'(exp.line)) begin
            report_mismatch("rd_blen_o", rd_blen_o, exp.line);
          end
          if (!rd_id_o && rd_blen_o != (exp.nc ? 2'd0 : 2'd3)) begin
            report_mismatch("rd_blen_o", rd_blen_o, exp.nc ? 2'd0 : 2'd3);
          end
          if (rd_size_o != (rd_id_o ? exp.size : 2'd3)) begin
            report_mismatch("rd_size_o", rd_size_o, rd_id_o ? exp.size : 2'd3);
          end
        end
        b.blen = rd_blen_o;
        b.id = rd_id_o;
        b.base = rd_addr_o & ~(paddr_t'((int'(rd_blen_o) + 1) * 8 - 1));
        burst_q.push_back(b);
      end
      if (wr_req_o && wr_gnt_i) begin
        exp = dc_bus_q.size() > 0 ? dc_bus_q.pop_front() : '0;
        if (!exp.store) begin
          $display("bus write without a pending store at t=%0t", $time);
          other_errors++;
        end else begin
          if (wr_addr_o != exp.addr) report_mismatch("wr_addr_o", wr_addr_o, exp.addr);
          if (wr_data_o != exp.wdata) report_mismatch("wr_data_o", wr_data_o, exp.wdata);
          if (wr_be_o != expected_be(exp.addr, exp.size)) begin
            report_mismatch("wr_be_o", wr_be_o, expected_be(exp.addr, exp.size));
          end
        end
        write_pending++;
      end
      // a store ack seen now left the response count at the previous edge
      if (dcache_rtrn_vld_o && dcache_rtrn_type_o == DCACHE_STORE_ACK) begin
        resp_unacked--;
      end
      if (wr_rdy_o != (resp_unacked < META_FIFO_DEPTH)) begin
        report_mismatch("wr_rdy_o", wr_rdy_o, resp_unacked < META_FIFO_DEPTH);
      end
      if (wr_resp_valid_i && wr_rdy_o) begin
        write_pending--;
        resp_unacked++;
      end
      wr_resp_valid_i <= (write_pending > 0) && r[4];
      rd_gnt_i <= r[5] | r[6];
      wr_gnt_i <= r[7] | r[8];
      // bursts go out one at a time with random gaps
      if (!beat_active && burst_q.size() > 0) begin
        cur = burst_q.pop_front();
        beat_active = 1'b1;
        beat_idx = 0;
      end
      rd_valid_i <= 1'b0;
      if (beat_active && r[11:9] != 3'b000) begin
        rd_valid_i <= 1'b1;
        rd_id_i <= cur.id;
        rd_data_i <= mem_word(cur.base + paddr_t'(beat_idx * 8));
        rd_last_i <= (beat_idx == int'(cur.blen));
        if (beat_idx == int'(cur.blen)) begin
          beat_active = 1'b0;
        end
        beat_idx++;
      end
    end
  end

  ////////////////////
  // return checker

  always @(posedge clk_i) begin
    req_rec_t exp;
    paddr_t base;
    if (arst_n_i && icache_rtrn_vld_o) begin
      returned++;
      if (ic_rtrn_q.size() == 0) begin
        $display("unexpected icache return at t=%0t", $time);
        other_errors++;
      end else begin
        exp = ic_rtrn_q.pop_front();
        if (icache_rtrn_tid_o != exp.tid) begin
          report_mismatch("icache_rtrn_tid_o", icache_rtrn_tid_o, exp.tid);
        end
        base = exp.nc ? (exp.addr & ~32'h7) : (exp.addr & ~32'h1f);
        for (int k = 0; k < (exp.nc ? 1 : ICACHE_LINE_WORDS); k++) begin
          if (icache_rtrn_data_o[k] != mem_word(base + paddr_t'(8 * k))) begin
            report_mismatch($sformatf("icache_rtrn_data_o[%0d]", k),
                            icache_rtrn_data_o[k], mem_word(base + paddr_t'(8 * k)));
          end
        end
      end
    end
    if (arst_n_i && dcache_rtrn_vld_o) begin
      returned++;
      if (dcache_rtrn_type_o == DCACHE_STORE_ACK) begin
        if (st_rtrn_q.size() == 0) begin
          $display("store ack with no store outstanding at t=%0t", $time);
          other_errors++;
        end else begin
          exp = st_rtrn_q.pop_front();
          if (dcache_rtrn_tid_o != exp.tid) begin
            report_mismatch("dcache_rtrn_tid_o", dcache_rtrn_tid_o, exp.tid);
          end
        end
      end else if (ld_rtrn_q.size() == 0) begin
        $display("load ack with no load outstanding at t=%0t", $time);
        other_errors++;
      end else begin
        exp = ld_rtrn_q.pop_front();
        if (dcache_rtrn_tid_o != exp.tid) begin
          report_mismatch("dcache_rtrn_tid_o", dcache_rtrn_tid_o, exp.tid);
        end
        base = exp.line ? (exp.addr & ~32'hf) : (exp.addr & ~32'h7);
        for (int k = 0; k < (exp.line ? DCACHE_LINE_WORDS : 1); k++) begin
          if (dcache_rtrn_data_o[k] != mem_word(base + paddr_t'(8 * k))) begin
            report_mismatch($sformatf("dcache_rtrn_data_o[%0d]", k),
                            dcache_rtrn_data_o[k], mem_word(base + paddr_t'(8 * k)));
          end
        end
      end
    end
  end

  ////////////////////
  // timeout and verdict

  always @(posedge clk_i) begin
    cycles++;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with %0d of %0d returns seen",
               cycles, returned, 2 * REQS_PER_CACHE);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    wait (returned == 2 * REQS_PER_CACHE);
    repeat (10) @(posedge clk_i);
    if (returned != 2 * REQS_PER_CACHE || ic_rtrn_q.size() != 0 || ld_rtrn_q.size() != 0
        || st_rtrn_q.size() != 0 || burst_q.size() != 0) begin
      $display("return count or outstanding queues wrong at the end of the run");
      other_errors++;
    end
    $display("errors: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: testbench/tb_cache_bus_adapter_assert.sv
/* Bus handshake and reset assertions bound to the adapter top level */
`timescale 1ns/100ps
module tb_cache_bus_adapter_assert import cache_bus_pkg::*; (
  input logic       clk_i,
  input logic       arst_n_i,
  input logic       rd_req_o,
  input logic       rd_gnt_i,
  input paddr_t     rd_addr_o,
  input blen_t      rd_blen_o,
  input logic [1:0] rd_size_o,
  input logic       rd_id_o,
  input logic       wr_req_o,
  input logic       wr_gnt_i,
  input paddr_t     wr_addr_o,
  input word_t      wr_data_o,
  input be_t        wr_be_o,
  input logic       icache_rtrn_vld_o,
  input logic       dcache_rtrn_vld_o
);

  // a waiting read request keeps its fields
  rd_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_req_o && !rd_gnt_i |=> rd_req_o && $stable(rd_addr_o) && $stable(rd_blen_o)
      && $stable(rd_size_o) && $stable(rd_id_o))
    else $error("read request changed before grant");

  wr_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_req_o && !wr_gnt_i |=> wr_req_o && $stable(wr_addr_o) && $stable(wr_data_o)
      && $stable(wr_be_o))
    else $error("write request changed before grant");

  // no return strobe in the first cycle out of reset
  rst_quiet: assert property (@(posedge clk_i)
    $rose(arst_n_i) |=> !icache_rtrn_vld_o && !dcache_rtrn_vld_o)
    else $error("return valid high after reset release");

endmodule

bind cache_bus_adapter tb_cache_bus_adapter_assert cache_bus_adapter_assert_inst (
  .clk_i, .arst_n_i, .rd_req_o, .rd_gnt_i, .rd_addr_o, .rd_blen_o, .rd_size_o, .rd_id_o,
  .wr_req_o, .wr_gnt_i, .wr_addr_o, .wr_data_o, .wr_be_o,
  .icache_rtrn_vld_o, .dcache_rtrn_vld_o
);

// File: logic/cache_bus_adapter.sv
/* Adapter from the instruction cache and the write-through data cache
   to a split read/write memory bus */
`timescale 1ns/100ps
module cache_bus_adapter import cache_bus_pkg::*; (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // instruction cache
  input  logic                          icache_data_req_i,
  output logic                          icache_data_ack_o,
  input  paddr_t                        icache_paddr_i,
  input  logic                          icache_nc_i,
  input  tid_t                          icache_tid_i,
  output logic                          icache_rtrn_vld_o,
  output tid_t                          icache_rtrn_tid_o,
  output word_t [ICACHE_LINE_WORDS-1:0] icache_rtrn_data_o,
  // data cache
  input  logic                          dcache_data_req_i,
  output logic                          dcache_data_ack_o,
  input  dcache_rtype_e                 dcache_rtype_i,
  input  paddr_t                        dcache_paddr_i,
  input  dsize_t                        dcache_size_i,
  input  word_t                         dcache_wdata_i,
  input  tid_t                          dcache_tid_i,
  output logic                          dcache_rtrn_vld_o,
  output dcache_rtrn_e                  dcache_rtrn_type_o,
  output tid_t                          dcache_rtrn_tid_o,
  output word_t [DCACHE_LINE_WORDS-1:0] dcache_rtrn_data_o,
  // bus read
  output logic                          rd_req_o,
  input  logic                          rd_gnt_i,
  output paddr_t                        rd_addr_o,
  output blen_t                         rd_blen_o,
  output logic [1:0]                    rd_size_o,
  output logic                          rd_id_o,
  input  logic                          rd_valid_i,
  input  word_t                         rd_data_i,
  input  logic                          rd_last_i,
  input  logic                          rd_id_i,
  // bus write
  output logic                          wr_req_o,
  input  logic                          wr_gnt_i,
  output paddr_t                        wr_addr_o,
  output word_t                         wr_data_o,
  output be_t                           wr_be_o,
  input  logic                          wr_resp_valid_i,
  output logic                          wr_rdy_o
);

  logic [PADDR_WIDTH+TID_WIDTH:0]              icache_req_head;
  logic [PADDR_WIDTH+TID_WIDTH+WORD_WIDTH+3:0] dcache_req_head;
  logic   icache_req_full, icache_req_empty, dcache_req_full, dcache_req_empty;
  logic   icache_id_full, dcache_rd_id_full, dcache_wr_id_full;
  logic   icache_pop, dcache_pop;
  logic   icache_id_pop, dcache_rd_id_pop, dcache_wr_id_pop;
  tid_t   icache_id_head, dcache_rd_id_head, dcache_wr_id_head;
  logic   icache_beat, dcache_beat;
  logic   wr_pending, wr_take;
  // request queue head fields
  logic   icache_nc, dcache_rtype;
  tid_t   icache_tid, dcache_tid;
  paddr_t icache_paddr, dcache_paddr;
  dsize_t dcache_size;
  word_t  dcache_wdata;

  assign icache_data_ack_o = ~icache_req_full;
  assign dcache_data_ack_o = ~dcache_req_full;
  assign {icache_nc, icache_tid, icache_paddr} = icache_req_head;
  assign {dcache_rtype, dcache_size, dcache_wdata, dcache_tid, dcache_paddr} = dcache_req_head;

  ////////////////////
  // request queues

  id_fifo #(.WIDTH(PADDR_WIDTH + TID_WIDTH + 1), .DEPTH(REQ_FIFO_DEPTH)) icache_req_fifo_inst (
    .clk_i, .arst_n_i, .push_i(icache_data_req_i),
    .data_i({icache_nc_i, icache_tid_i, icache_paddr_i}),
    .pop_i(icache_pop), .data_o(icache_req_head),
    .full_o(icache_req_full), .empty_o(icache_req_empty)
  );

  id_fifo #(
    .WIDTH(PADDR_WIDTH + TID_WIDTH + WORD_WIDTH + 4), .DEPTH(REQ_FIFO_DEPTH)
  ) dcache_req_fifo_inst (
    .clk_i, .arst_n_i, .push_i(dcache_data_req_i),
    .data_i({dcache_rtype_i, dcache_size_i, dcache_wdata_i, dcache_tid_i, dcache_paddr_i}),
    .pop_i(dcache_pop), .data_o(dcache_req_head),
    .full_o(dcache_req_full), .empty_o(dcache_req_empty)
  );

  // a cache only competes while its id queues have room
  req_arbiter req_arbiter_inst (
    .clk_i, .arst_n_i,
    .icache_valid_i(~icache_req_empty & ~icache_id_full),
    .icache_paddr_i(icache_paddr), .icache_nc_i(icache_nc),
    .dcache_valid_i(~dcache_req_empty & ~dcache_rd_id_full & ~dcache_wr_id_full),
    .dcache_rtype_i(dcache_rtype_e'(dcache_rtype)), .dcache_paddr_i(dcache_paddr),
    .dcache_size_i(dcache_size), .dcache_wdata_i(dcache_wdata),
    .rd_gnt_i, .wr_gnt_i, .icache_pop_o(icache_pop), .dcache_pop_o(dcache_pop),
    .rd_req_o, .rd_addr_o, .rd_blen_o, .rd_size_o, .rd_id_o,
    .wr_req_o, .wr_addr_o, .wr_data_o, .wr_be_o
  );

  ////////////////////
  // id queues

  id_fifo #(.WIDTH(TID_WIDTH), .DEPTH(META_FIFO_DEPTH)) icache_id_fifo_inst (
    .clk_i, .arst_n_i, .push_i(icache_pop), .data_i(icache_tid),
    .pop_i(icache_id_pop), .data_o(icache_id_head), .full_o(icache_id_full), .empty_o()
  );

  id_fifo #(.WIDTH(TID_WIDTH), .DEPTH(META_FIFO_DEPTH)) dcache_rd_id_fifo_inst (
    .clk_i, .arst_n_i, .push_i(dcache_pop & rd_req_o), .data_i(dcache_tid),
    .pop_i(dcache_rd_id_pop), .data_o(dcache_rd_id_head), .full_o(dcache_rd_id_full), .empty_o()
  );

  id_fifo #(.WIDTH(TID_WIDTH), .DEPTH(META_FIFO_DEPTH)) dcache_wr_id_fifo_inst (
    .clk_i, .arst_n_i, .push_i(dcache_pop & wr_req_o), .data_i(dcache_tid),
    .pop_i(dcache_wr_id_pop), .data_o(dcache_wr_id_head), .full_o(dcache_wr_id_full), .empty_o()
  );

  ////////////////////
  // return path

  wr_resp_counter wr_resp_counter_inst (
    .clk_i, .arst_n_i, .wr_resp_valid_i, .take_i(wr_take), .wr_rdy_o, .pending_o(wr_pending)
  );

  rtrn_router rtrn_router_inst (
    .clk_i, .arst_n_i, .rd_valid_i, .rd_last_i, .rd_id_i, .wr_pending_i(wr_pending),
    .icache_tid_i(icache_id_head), .dcache_rd_tid_i(dcache_rd_id_head),
    .dcache_wr_tid_i(dcache_wr_id_head),
    .icache_beat_o(icache_beat), .dcache_beat_o(dcache_beat),
    .icache_tid_pop_o(icache_id_pop), .dcache_rd_tid_pop_o(dcache_rd_id_pop),
    .dcache_wr_tid_pop_o(dcache_wr_id_pop), .wr_take_o(wr_take),
    .icache_rtrn_vld_o, .icache_rtrn_tid_o,
    .dcache_rtrn_vld_o, .dcache_rtrn_type_o, .dcache_rtrn_tid_o
  );

  line_assembler #(.LINE_WORDS(ICACHE_LINE_WORDS)) icache_line_inst (
    .clk_i, .arst_n_i, .beat_i(icache_beat), .last_i(rd_last_i), .data_i(rd_data_i),
    .line_o(icache_rtrn_data_o)
  );

  line_assembler #(.LINE_WORDS(DCACHE_LINE_WORDS)) dcache_line_inst (
    .clk_i, .arst_n_i, .beat_i(dcache_beat), .last_i(rd_last_i), .data_i(rd_data_i),
    .line_o(dcache_rtrn_data_o)
  );

endmodule

// File: logic/rtrn_router.sv
/* Return path steering: read beats by bus id, write responses to store acks,
   id queue pops and the registered return strobes of both caches */
`timescale 1ns/100ps
module rtrn_router import cache_bus_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         rd_valid_i,
  input  logic         rd_last_i,
  input  logic         rd_id_i,
  input  logic         wr_pending_i,
  input  tid_t         icache_tid_i,
  input  tid_t         dcache_rd_tid_i,
  input  tid_t         dcache_wr_tid_i,
  output logic         icache_beat_o,
  output logic         dcache_beat_o,
  output logic         icache_tid_pop_o,
  output logic         dcache_rd_tid_pop_o,
  output logic         dcache_wr_tid_pop_o,
  output logic         wr_take_o,
  output logic         icache_rtrn_vld_o,
  output tid_t         icache_rtrn_tid_o,
  output logic         dcache_rtrn_vld_o,
  output dcache_rtrn_e dcache_rtrn_type_o,
  output tid_t         dcache_rtrn_tid_o
);

  ////////////////////
  // beat steering

  // bus id 0 belongs to the icache, 1 to the dcache
  assign icache_beat_o = rd_valid_i & ~rd_id_i;
  assign dcache_beat_o = rd_valid_i & rd_id_i;

  assign icache_tid_pop_o    = icache_beat_o & rd_last_i;
  assign dcache_rd_tid_pop_o = dcache_beat_o & rd_last_i;

  // store acks wait while the dcache read channel is busy
  assign wr_take_o           = wr_pending_i & ~dcache_beat_o;
  assign dcache_wr_tid_pop_o = wr_take_o;

  ////////////////////
  // return registers

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      icache_rtrn_vld_o <= 1'b0;
      dcache_rtrn_vld_o <= 1'b0;
    end else begin
      icache_rtrn_vld_o <= icache_tid_pop_o;
      dcache_rtrn_vld_o <= dcache_rd_tid_pop_o | wr_take_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (icache_tid_pop_o) begin
      icache_rtrn_tid_o <= icache_tid_i;
    end
    if (dcache_rd_tid_pop_o) begin
      dcache_rtrn_tid_o  <= dcache_rd_tid_i;
      dcache_rtrn_type_o <= DCACHE_LOAD_ACK;
    end else if (wr_take_o) begin
      dcache_rtrn_tid_o  <= dcache_wr_tid_i;
      dcache_rtrn_type_o <= DCACHE_STORE_ACK;
    end
  end

endmodule

// File: logic/line_assembler.sv
/* Builds a cache line from read beats in a shift register;
   the line holds in the cycle after the last beat */
`timescale 1ns/100ps
module line_assembler import cache_bus_pkg::*; #(
  parameter int LINE_WORDS = DCACHE_LINE_WORDS
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   beat_i,
  input  logic                   last_i,
  input  word_t                  data_i,
  output word_t [LINE_WORDS-1:0] line_o
);

  word_t [LINE_WORDS-1:0] line_q;
  logic                   first_q;

  // each beat enters at the top word and pushes the rest down
  always_ff @(posedge clk_i) begin
    if (beat_i) begin
      line_q <= {data_i, line_q[LINE_WORDS-1:1]};
      // single-word reads must end up in word 0
      if (first_q) begin
        line_q[0] <= data_i;
      end
    end
  end

  // next beat opens a new burst after a last beat
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      first_q <= 1'b1;
    end else if (beat_i) begin
      first_q <= last_i;
    end
  end

  assign line_o = line_q;

endmodule

// File: logic/wr_resp_counter.sv
/* Counts write responses taken from the bus and not yet turned into store acks */
`timescale 1ns/100ps
module wr_resp_counter import cache_bus_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic wr_resp_valid_i,
  input  logic take_i,
  output logic wr_rdy_o,
  output logic pending_o
);

  logic [$clog2(META_FIFO_DEPTH+1)-1:0] count_q;
  logic                                 accept;

  // stop the response channel once every slot is used
  assign wr_rdy_o  = (count_q != ($clog2(META_FIFO_DEPTH+1))'(META_FIFO_DEPTH));
  assign pending_o = (count_q != '0);
  assign accept    = wr_resp_valid_i & wr_rdy_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (accept && !take_i) begin
      count_q <= count_q + 1'b1;
    end else if (take_i && !accept) begin
      count_q <= count_q - 1'b1;
    end
  end

endmodule

// File: logic/req_arbiter.sv
/* Round-robin arbiter between the two cache request queues; locks the winner
   until the bus grants it and decodes it into a read burst or a single write */
`timescale 1ns/100ps
module req_arbiter import cache_bus_pkg::*; (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          icache_valid_i,
  input  paddr_t        icache_paddr_i,
  input  logic          icache_nc_i,
  input  logic          dcache_valid_i,
  input  dcache_rtype_e dcache_rtype_i,
  input  paddr_t        dcache_paddr_i,
  input  dsize_t        dcache_size_i,
  input  word_t         dcache_wdata_i,
  input  logic          rd_gnt_i,
  input  logic          wr_gnt_i,
  output logic          icache_pop_o,
  output logic          dcache_pop_o,
  output logic          rd_req_o,
  output paddr_t        rd_addr_o,
  output blen_t         rd_blen_o,
  output logic [1:0]    rd_size_o,
  output logic          rd_id_o,
  output logic          wr_req_o,
  output paddr_t        wr_addr_o,
  output word_t         wr_data_o,
  output be_t           wr_be_o
);

  arb_state_e state_q;
  arb_state_e state_d;
  logic       sel_dcache;
  logic       req_vld;
  logic       gnt;

  ////////////////////
  // winner select

  always_comb begin
    case (state_q)
      ARB_HOLD_ICACHE: sel_dcache = 1'b0;
      ARB_HOLD_DCACHE: sel_dcache = 1'b1;
      ARB_PRIO_DCACHE: sel_dcache = dcache_valid_i | ~icache_valid_i;
      default:         sel_dcache = dcache_valid_i & ~icache_valid_i;
    endcase
  end

  assign req_vld  = sel_dcache ? dcache_valid_i : icache_valid_i;
  assign rd_req_o = req_vld & (~sel_dcache | (dcache_rtype_i == DCACHE_LOAD_REQ));
  assign wr_req_o = req_vld & sel_dcache & (dcache_rtype_i == DCACHE_STORE_REQ);
  assign gnt      = (rd_req_o & rd_gnt_i) | (wr_req_o & wr_gnt_i);

  // the granted head leaves its queue in the grant cycle
  assign icache_pop_o = gnt & ~sel_dcache;
  assign dcache_pop_o = gnt & sel_dcache;

  // lock on a waiting winner, hand priority over after a grant
  always_comb begin
    state_d = state_q;
    if (gnt) begin
      state_d = sel_dcache ? ARB_PRIO_ICACHE : ARB_PRIO_DCACHE;
    end else if (req_vld) begin
      state_d = sel_dcache ? ARB_HOLD_DCACHE : ARB_HOLD_ICACHE;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ARB_PRIO_ICACHE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // bus decode

  assign rd_id_o   = sel_dcache;
  assign rd_addr_o = sel_dcache ? dcache_paddr_i : icache_paddr_i;
  // instruction fetches always use full words
  assign rd_size_o = sel_dcache ? dcache_size_i[1:0] : 2'b11;

  always_comb begin
    rd_blen_o = '0;
    if (sel_dcache) begin
      if (dcache_size_i[2]) begin
        rd_blen_o = blen_t'(DCACHE_LINE_WORDS - 1);
      end
    end else if (!icache_nc_i) begin
      rd_blen_o = blen_t'(ICACHE_LINE_WORDS - 1);
    end
  end

  // stores are single words
  assign wr_addr_o = dcache_paddr_i;
  assign wr_data_o = dcache_wdata_i;
  assign wr_be_o   = to_byte_enable(dcache_paddr_i[2:0], dcache_size_i[1:0]);

endmodule

// File: logic/id_fifo.sv
/* Small register queue used for cache requests and transaction ids;
   the head word shows one cycle after the push */
`timescale 1ns/100ps
module id_fifo import cache_bus_pkg::*; #(
  parameter int WIDTH = TID_WIDTH,
  parameter int DEPTH = META_FIFO_DEPTH
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  logic [WIDTH-1:0]           mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic                       push_en;
  logic                       pop_en;

  // push into a full queue or pop from an empty one is ignored
  assign push_en = push_i & ~full_o;
  assign pop_en  = pop_i & ~empty_o;

  assign full_o  = (count_q == ($clog2(DEPTH+1))'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // pointers wrap on their own for a power-of-two depth
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: logic/cache_bus_pkg.sv
/* Shared widths, line sizes, request and return encodings of the cache to bus adapter,
   plus the store byte-enable rule */
package cache_bus_pkg;

  // bus and address geometry
  localparam int PADDR_WIDTH       = 32;
  localparam int WORD_WIDTH        = 64;
  localparam int ICACHE_LINE_WORDS = 4;
  localparam int DCACHE_LINE_WORDS = 2;

  // queue sizing
  localparam int TID_WIDTH       = 2;
  localparam int REQ_FIFO_DEPTH  = 2;
  localparam int META_FIFO_DEPTH = 4;

  // beats minus one of the longer line
  localparam int BLEN_WIDTH = 2;

  typedef logic [PADDR_WIDTH-1:0]  paddr_t;
  typedef logic [WORD_WIDTH-1:0]   word_t;
  typedef logic [WORD_WIDTH/8-1:0] be_t;
  typedef logic [TID_WIDTH-1:0]    tid_t;
  typedef logic [BLEN_WIDTH-1:0]   blen_t;

  // bit 2 selects a full line, bits 1:0 give log2 of the byte count
  typedef logic [2:0] dsize_t;

  typedef enum logic {DCACHE_LOAD_REQ, DCACHE_STORE_REQ} dcache_rtype_e;
  typedef enum logic {DCACHE_LOAD_ACK, DCACHE_STORE_ACK} dcache_rtrn_e;

  typedef enum logic [1:0] {
    ARB_PRIO_ICACHE,
    ARB_PRIO_DCACHE,
    ARB_HOLD_ICACHE,
    ARB_HOLD_DCACHE
  } arb_state_e;

  // naturally aligned enables, offset rounded down to the access size
  function automatic be_t to_byte_enable(input logic [2:0] offset, input logic [1:0] size);
    be_t be;
    case (size)
      2'b00:   be = be_t'(8'h01) << offset;
      2'b01:   be = be_t'(8'h03) << {offset[2:1], 1'b0};
      2'b10:   be = be_t'(8'h0f) << {offset[2], 2'b00};
      default: be = '1;
    endcase
    return be;
  endfunction

endpackage
